//--- Bender.yml
package:
  name: boot_iccm

sources:
  - files:
      - hdl/boot_pkg.sv
      - hdl/uart_rx_byte.sv
      - hdl/iccm_loader.sv
      - hdl/rst_ctrl.sv
      - hdl/iccm_dispatch.sv
      - hdl/iccm_bank.sv
      - hdl/iccm_read_mux.sv
      - hdl/boot_top.sv
  - target: test
    files:
      - tb/boot_props.sv
      - tb/tb_boot_top.sv

//--- hdl/boot_pkg.sv
package boot_pkg;

  // instruction word and word address
  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;

  // memory split into interleaved banks
  localparam int NUM_BANKS  = 4;
  localparam int BANK_SEL_W = 2;

  // row inside one bank, upper address bits
  localparam int ROW_W      = ADDR_W - BANK_SEL_W;
  localparam int BANK_DEPTH = 1 << ROW_W;

  // word that closes a program, never stored
  localparam logic [DATA_W-1:0] END_MARKER = 32'h0000_0FFF;

  // bit period input of the serial receiver
  localparam int CPB_W = 16;

endpackage

//--- hdl/boot_top.sv
`timescale 1ns/1ns

module boot_top import boot_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              uart_rx_i,
  input  logic [CPB_W-1:0]  clks_per_bit_i,
  input  logic              dbg_reset_i,
  input  logic              fetch_req_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic [DATA_W-1:0] fetch_rdata_o,
  output logic              fetch_rvalid_o,
  output logic              sys_reset_o,
  output logic              prog_busy_o
);

  logic                        rx_dv;
  logic [7:0]                  rx_byte;
  logic                        ld_we;
  logic [ADDR_W-1:0]           ld_addr;
  logic [DATA_W-1:0]           ld_wdata;
  logic                        ld_busy;
  logic                        sys_reset;
  logic [NUM_BANKS-1:0]        bank_req;
  logic                        bank_we;
  logic [ROW_W-1:0]            bank_row;
  logic [DATA_W-1:0]           bank_wdata;
  logic [BANK_SEL_W-1:0]       rd_sel;
  logic                        rd_en;
  logic [NUM_BANKS*DATA_W-1:0] bank_rdata;

  // boot loader path
  uart_rx_byte u_uart_rx (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .rx_i           (uart_rx_i),
    .clks_per_bit_i (clks_per_bit_i),
    .rx_dv_o        (rx_dv),
    .rx_byte_o      (rx_byte)
  );

  iccm_loader u_loader (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rx_dv_i   (rx_dv),
    .rx_byte_i (rx_byte),
    .we_o      (ld_we),
    .addr_o    (ld_addr),
    .wdata_o   (ld_wdata),
    .busy_o    (ld_busy)
  );

  rst_ctrl u_rst_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ndm_reset_i (dbg_reset_i),
    .prog_busy_i (ld_busy),
    .sys_reset_o (sys_reset)
  );

  // memory side
  iccm_dispatch u_dispatch (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .sys_reset_i  (sys_reset),
    .ld_we_i      (ld_we),
    .ld_addr_i    (ld_addr),
    .ld_wdata_i   (ld_wdata),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_row_o   (bank_row),
    .bank_wdata_o (bank_wdata),
    .rd_sel_o     (rd_sel),
    .rd_en_o      (rd_en)
  );

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    iccm_bank u_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req[g]),
      .we_i    (bank_we),
      .row_i   (bank_row),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata[g*DATA_W +: DATA_W])
    );
  end

  iccm_read_mux u_read_mux (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rd_sel_i     (rd_sel),
    .rd_en_i      (rd_en),
    .bank_rdata_i (bank_rdata),
    .rdata_o      (fetch_rdata_o),
    .rvalid_o     (fetch_rvalid_o)
  );

  assign sys_reset_o = sys_reset;
  assign prog_busy_o = ld_busy;

endmodule

//--- hdl/iccm_bank.sv
`timescale 1ns/1ns

module iccm_bank import boot_pkg::*; (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ROW_W-1:0]  row_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [BANK_DEPTH];
  logic [DATA_W-1:0] rdata_q;

  // contents survive every system reset
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[row_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[row_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/iccm_dispatch.sv
`timescale 1ns/1ns

module iccm_dispatch import boot_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sys_reset_i,
  input  logic                  ld_we_i,
  input  logic [ADDR_W-1:0]     ld_addr_i,
  input  logic [DATA_W-1:0]     ld_wdata_i,
  input  logic                  fetch_req_i,
  input  logic [ADDR_W-1:0]     fetch_addr_i,
  output logic [NUM_BANKS-1:0]  bank_req_o,
  output logic                  bank_we_o,
  output logic [ROW_W-1:0]      bank_row_o,
  output logic [DATA_W-1:0]     bank_wdata_o,
  output logic [BANK_SEL_W-1:0] rd_sel_o,
  output logic                  rd_en_o
);

  logic [ADDR_W-1:0]     addr;
  logic                  access;
  logic                  rd_take;
  logic [BANK_SEL_W-1:0] sel;
  logic [BANK_SEL_W-1:0] rd_sel_q;
  logic                  rd_en_q;

  // loader owns the memory while the system is in reset
  assign addr    = sys_reset_i ? ld_addr_i : fetch_addr_i;
  assign access  = sys_reset_i ? ld_we_i : fetch_req_i;
  assign rd_take = fetch_req_i && !sys_reset_i;

  // low bits pick the bank, so neighbouring words interleave
  assign sel        = addr[BANK_SEL_W-1:0];
  assign bank_row_o = addr[ADDR_W-1:BANK_SEL_W];

  always_comb begin
    bank_req_o = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b] = access && (sel == BANK_SEL_W'(b));
    end
  end

  assign bank_we_o    = sys_reset_i && ld_we_i;
  assign bank_wdata_o = ld_wdata_i;

  // bank index follows the read into the data cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_sel_q <= '0;
      rd_en_q  <= 1'b0;
    end else begin
      rd_en_q <= rd_take;
      if (rd_take) begin
        rd_sel_q <= sel;
      end
    end
  end

  assign rd_sel_o = rd_sel_q;
  assign rd_en_o  = rd_en_q;

endmodule

//--- hdl/iccm_loader.sv
`timescale 1ns/1ns

module iccm_loader import boot_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              rx_dv_i,
  input  logic [7:0]        rx_byte_i,
  output logic              we_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [DATA_W-1:0] wdata_o,
  output logic              busy_o
);

  logic [1:0]        byte_cnt_q;
  logic [DATA_W-1:0] word_q;
  logic [DATA_W-1:0] word_next;
  logic [DATA_W-1:0] wdata_q;
  logic [ADDR_W-1:0] addr_q;
  logic              we_q;
  logic              busy_q;
  logic              byte_take;

  // little endian, newest byte enters at the top
  assign word_next = {rx_byte_i, word_q[DATA_W-1:8]};
  assign byte_take = rx_dv_i && busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      byte_cnt_q <= '0;
      addr_q     <= '0;
      we_q       <= 1'b0;
      busy_q     <= 1'b1;
    end else begin
      we_q <= 1'b0;
      if (we_q) begin
        addr_q <= addr_q + 1'b1;
      end
      if (byte_take) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
        if (byte_cnt_q == 2'd3) begin
          if (word_next == END_MARKER) begin
            busy_q <= 1'b0;
          end else begin
            we_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_take) begin
      word_q <= word_next;
      if (byte_cnt_q == 2'd3) begin
        wdata_q <= word_next;
      end
    end
  end

  assign we_o    = we_q;
  assign addr_o  = addr_q;
  assign wdata_o = wdata_q;
  assign busy_o  = busy_q;

endmodule

//--- hdl/iccm_read_mux.sv
`timescale 1ns/1ns

module iccm_read_mux import boot_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [BANK_SEL_W-1:0]         rd_sel_i,
  input  logic                          rd_en_i,
  input  logic [NUM_BANKS*DATA_W-1:0]   bank_rdata_i,
  output logic [DATA_W-1:0]             rdata_o,
  output logic                          rvalid_o
);

  logic [DATA_W-1:0] picked;
  logic [DATA_W-1:0] hold_q;

  assign picked = bank_rdata_i[rd_sel_i*DATA_W +: DATA_W];

  // last returned word stays on the port between reads
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hold_q <= '0;
    end else if (rd_en_i) begin
      hold_q <= picked;
    end
  end

  assign rdata_o  = rd_en_i ? picked : hold_q;
  assign rvalid_o = rd_en_i;

endmodule

//--- hdl/rst_ctrl.sv
`timescale 1ns/1ns

module rst_ctrl (
  input  logic clk_i,
  input  logic reset_i,
  input  logic ndm_reset_i,
  input  logic prog_busy_i,
  output logic sys_reset_o
);

  logic sys_reset_q;

  // one cycle behind the sources, no glitches reach the soc
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sys_reset_q <= 1'b1;
    end else begin
      sys_reset_q <= ndm_reset_i | prog_busy_i;
    end
  end

  assign sys_reset_o = sys_reset_q;

endmodule

//--- hdl/uart_rx_byte.sv
`timescale 1ns/1ns

module uart_rx_byte import boot_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             rx_i,
  input  logic [CPB_W-1:0] clks_per_bit_i,
  output logic             rx_dv_o,
  output logic [7:0]       rx_byte_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_e;

  rx_state_e        state_q;
  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [CPB_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             dv_q;
  logic [7:0]       byte_q;
  logic [CPB_W-1:0] half_period;
  logic             full_period;

  // line idles high, so the synchronizer resets to one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign half_period = clks_per_bit_i >> 1;
  assign full_period = (cnt_q == clks_per_bit_i - 1'b1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      dv_q      <= 1'b0;
    end else begin
      dv_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= ST_START;
          end
        end
        // confirm the start bit in its middle
        ST_START: begin
          if (cnt_q == half_period - 1'b1) begin
            cnt_q   <= '0;
            state_q <= rx_sync_q ? ST_IDLE : ST_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // one full period later lands mid bit, lsb first
        ST_DATA: begin
          if (full_period) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_STOP: begin
          if (full_period) begin
            cnt_q   <= '0;
            state_q <= ST_IDLE;
            // framing error drops the byte silently
            dv_q    <= rx_sync_q;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // data path
  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && full_period) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
    if (state_q == ST_STOP && full_period && rx_sync_q) begin
      byte_q <= shift_q;
    end
  end

  assign rx_dv_o   = dv_q;
  assign rx_byte_o = byte_q;

endmodule

//--- tb/boot_props.sv
`timescale 1ns/1ns

module boot_props import boot_pkg::*; (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic [NUM_BANKS-1:0] bank_req_i,
  input logic                 ld_we_i,
  input logic                 sys_reset_i,
  input logic                 fetch_req_i,
  input logic                 fetch_rvalid_i
);

  // a single bank is addressed per cycle
  a_one_bank: assert property (
    @(posedge clk_i) disable iff (reset_i) $onehot0(bank_req_i)
  ) else $error("more than one bank strobe is high");

  // every valid comes from a read accepted outside system reset
  a_rvalid_source: assert property (
    @(posedge clk_i) disable iff (reset_i)
      fetch_rvalid_i |-> $past(fetch_req_i && !sys_reset_i)
  ) else $error("fetch valid without an accepted read one cycle earlier");

  // loader writes only land while the soc is held in reset
  a_write_in_reset: assert property (
    @(posedge clk_i) disable iff (reset_i)
      ld_we_i |-> sys_reset_i
  ) else $error("loader write while system reset is low");

endmodule

//--- tb/tb_boot_top.sv
`timescale 1ns/1ns

module tb_boot_top import boot_pkg::*; ();

  localparam int CPB         = 8;
  localparam int PROG_WORDS  = 16;
  localparam int LOAD_CYCLES = (PROG_WORDS + 1) * 4 * 10 * CPB;
  // reset, read burst, debug reset window, random reads
  localparam int READ_CYCLES = 10 + (PROG_WORDS + 2) + 8 + 22 + 4;
  localparam int MAX_CYCLES  = LOAD_CYCLES + READ_CYCLES + 500;

  logic              clk_i;
  logic              reset_i;
  logic              uart_rx_i;
  logic [CPB_W-1:0]  clks_per_bit_i;
  logic              dbg_reset_i;
  logic              fetch_req_i;
  logic [ADDR_W-1:0] fetch_addr_i;
  logic [DATA_W-1:0] fetch_rdata_o;
  logic              fetch_rvalid_o;
  logic              sys_reset_o;
  logic              prog_busy_o;

  integer            seed = 32'hea3f;
  int                cycle_cnt = 0;
  logic [ADDR_W-1:0] rd_addrs[$];

  // program image, also the expected read data
  logic [DATA_W-1:0] prog_table [PROG_WORDS] = '{
    32'h0000_0093, 32'h0010_0113, 32'h0020_0193, 32'h0030_0213,
    32'h0041_0133, 32'hdead_beef, 32'h1234_5678, 32'hffff_ffff,
    32'h0000_0000, 32'ha5a5_5a5a, 32'h0000_0ffe, 32'h8000_0001,
    32'h00c0_006f, 32'hfe01_0113, 32'h0011_2623, 32'h0000_8067
  };

  boot_top u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .uart_rx_i      (uart_rx_i),
    .clks_per_bit_i (clks_per_bit_i),
    .dbg_reset_i    (dbg_reset_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_rdata_o  (fetch_rdata_o),
    .fetch_rvalid_o (fetch_rvalid_o),
    .sys_reset_o    (sys_reset_o),
    .prog_busy_o    (prog_busy_o)
  );

  bind boot_top boot_props u_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bank_req_i     (bank_req),
    .ld_we_i        (ld_we),
    .sys_reset_i    (sys_reset_o),
    .fetch_req_i    (fetch_req_i),
    .fetch_rvalid_i (fetch_rvalid_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // 8N1 frame, lsb first, reads are probed on every cycle
  task automatic send_uart_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int k = 0; k < 10; k++) begin
      uart_rx_i = frame[k];
      for (int c = 0; c < CPB; c++) begin
        if (fetch_req_i) begin
          fetch_addr_i = ADDR_W'($random(seed));
        end
        step_cycle();
        check_bit("fetch_rvalid_o while loading", fetch_rvalid_o, 1'b0);
      end
    end
  endtask

  task automatic send_word(input logic [DATA_W-1:0] word);
    for (int b = 0; b < 4; b++) begin
      send_uart_byte(word[8*b +: 8]);
    end
  endtask

  // one read per cycle, data checked in the following cycle
  task automatic run_reads();
    for (int i = 0; i < rd_addrs.size(); i++) begin
      fetch_req_i  = 1'b1;
      fetch_addr_i = rd_addrs[i];
      step_cycle();
      check_bit("fetch_rvalid_o", fetch_rvalid_o, 1'b1);
      check_word("fetch_rdata_o", fetch_rdata_o, prog_table[rd_addrs[i][3:0]]);
    end
    fetch_req_i = 1'b0;
    step_cycle();
    check_bit("fetch_rvalid_o after reads", fetch_rvalid_o, 1'b0);
  endtask

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    uart_rx_i      = 1'b1;
    clks_per_bit_i = CPB_W'(CPB);
    dbg_reset_i    = 1'b0;
    fetch_req_i    = 1'b0;
    fetch_addr_i   = '0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    check_bit("sys_reset_o after reset", sys_reset_o, 1'b1);
    check_bit("prog_busy_o after reset", prog_busy_o, 1'b1);
    check_bit("fetch_rvalid_o after reset", fetch_rvalid_o, 1'b0);

    // load the program while the fetch port keeps asking
    fetch_req_i = 1'b1;
    for (int w = 0; w < PROG_WORDS; w++) begin
      send_word(prog_table[w]);
    end
    fetch_req_i = 1'b0;
    send_word(END_MARKER);

    while (prog_busy_o) begin
      step_cycle();
    end
    check_bit("sys_reset_o as busy falls", sys_reset_o, 1'b1);
    step_cycle();
    check_bit("sys_reset_o after busy", sys_reset_o, 1'b0);

    // all four banks, back to back
    for (int a = 0; a < PROG_WORDS; a++) begin
      rd_addrs.push_back(ADDR_W'(a));
    end
    run_reads();

    dbg_reset_i = 1'b1;
    step_cycle();
    check_bit("sys_reset_o with debug reset", sys_reset_o, 1'b1);
    for (int i = 0; i < 6; i++) begin
      fetch_req_i  = 1'b1;
      fetch_addr_i = ADDR_W'(i);
      step_cycle();
      check_bit("fetch_rvalid_o in debug reset", fetch_rvalid_o, 1'b0);
    end
    dbg_reset_i = 1'b0;
    fetch_req_i = 1'b0;
    step_cycle();
    check_bit("fetch_rvalid_o at debug release", fetch_rvalid_o, 1'b0);
    check_bit("sys_reset_o after debug release", sys_reset_o, 1'b0);

    // memory contents must survive the debug reset
    rd_addrs.delete();
    for (int i = 0; i < 20; i++) begin
      rd_addrs.push_back(ADDR_W'($random(seed) & 15));
    end
    run_reads();

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- vlog.f
hdl/boot_pkg.sv
hdl/uart_rx_byte.sv
hdl/iccm_loader.sv
hdl/rst_ctrl.sv
hdl/iccm_dispatch.sv
hdl/iccm_bank.sv
hdl/iccm_read_mux.sv
hdl/boot_top.sv
tb/boot_props.sv
tb/tb_boot_top.sv
